// File: Bender.yml
package:
  name: cart_loader

sources:
  - files:
      - design/cart_loader_pkg.sv
      - design/download_decode.sv
      - design/header_detect.sv
      - design/cheat_assemble.sv
      - design/cart_loader_top.sv
  - target: test
    files:
      - verif/cart_loader_assert.sv
      - verif/cart_loader_tb.sv

vendor_package: []

dependencies: {}

// File: design/cart_loader_pkg.sv
/* Cartridge loader shared definitions */

`default_nettype none

package cart_loader_pkg;

	// ==============================
	// Widths and download constants
	// ==============================
	localparam int ADDR_W = 25;
	localparam int DATA_W = 16;

	// Cartridge files carry a copier header in front of the image
	localparam int HEADER_SKIP = 512;

	// All-ones index marks a cheat file
	localparam logic [7:0] CHEAT_INDEX = 8'hFF;

	// One size code step doubles this many bytes
	localparam int MASK_BASE = 1024;
	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'hC;

	// ==============================
	// Header offsets, file relative
	// ==============================
	localparam logic [ADDR_W-1:0] LOROM_SIZE_ADDR = 25'h7FD6 + 25'(HEADER_SKIP);
	localparam logic [ADDR_W-1:0] LOROM_RAM_ADDR = 25'h7FD8 + 25'(HEADER_SKIP);
	localparam logic [ADDR_W-1:0] HIROM_SIZE_ADDR = 25'hFFD6 + 25'(HEADER_SKIP);
	localparam logic [ADDR_W-1:0] HIROM_RAM_ADDR = 25'hFFD8 + 25'(HEADER_SKIP);
	localparam logic [ADDR_W-1:0] EXHIROM_SIZE_ADDR = 25'h40FFD6 + 25'(HEADER_SKIP);
	localparam logic [ADDR_W-1:0] EXHIROM_RAM_ADDR = 25'h40FFD8 + 25'(HEADER_SKIP);

	// ==============================
	// Types
	// ==============================
	typedef enum logic [2:0] {
		HDR_AUTO = 3'd0,
		HDR_NONE = 3'd1,
		HDR_LOROM = 3'd2,
		HDR_HIROM = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_e;

	// One decoded download word
	typedef struct packed {
		logic is_cheat;
		logic [ADDR_W-1:0] addr;
		logic [ADDR_W-1:0] code_addr;
		logic [DATA_W-1:0] data;
	} dl_word_t;

	// Cartridge description for the console core
	typedef struct packed {
		logic [7:0] rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic region;
	} cart_info_t;

	// Cheat record, values kept big endian as delivered by the loader
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

// File: design/cart_loader_top.sv
/* Cartridge loader top level */

`default_nettype none

module cart_loader_top import cart_loader_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input logic download,
	input logic wr,
	input logic [7:0] index,
	input logic [ADDR_W-1:0] addr,
	input logic [DATA_W-1:0] data,
	input header_mode_e header_mode,
	output cart_info_t cart_info,
	output cheat_code_t cheat_code,
	output logic cheat_valid,
	output logic cheat_clear
);

	dl_word_t word;
	logic word_valid;
	logic cart_loading;
	logic cheat_loading;

	// Stage one feeds both consumers
	download_decode download_decode_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.download(download),
		.wr(wr),
		.index(index),
		.addr(addr),
		.data(data),
		.word(word),
		.word_valid(word_valid),
		.cart_loading(cart_loading),
		.cheat_loading(cheat_loading)
	);

	header_detect header_detect_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.word(word),
		.word_valid(word_valid),
		.cart_loading(cart_loading),
		.header_mode(header_mode),
		.cart_info(cart_info)
	);

	cheat_assemble cheat_assemble_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.word(word),
		.word_valid(word_valid),
		.cart_loading(cart_loading),
		.cheat_loading(cheat_loading),
		.cheat_code(cheat_code),
		.cheat_valid(cheat_valid),
		.cheat_clear(cheat_clear)
	);

endmodule

`default_nettype wire

// File: design/cheat_assemble.sv
/* Cheat record assembly */

`default_nettype none

module cheat_assemble import cart_loader_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input dl_word_t word,
	input logic word_valid,
	input logic cart_loading,
	input logic cheat_loading,
	output cheat_code_t cheat_code,
	output logic cheat_valid,
	output logic cheat_clear
);

	logic cheat_wr;
	logic first_word;

	// Word tag and download level must both say cheat
	assign cheat_wr = word_valid & cheat_loading & word.is_cheat;
	assign first_word = cheat_wr & (word.addr == '0);

	// ==============================
	// Record halves by address nibble
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cheat_code <= '0;
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= 1'b0;
			if (cheat_wr) begin
				case (word.code_addr[3:0])
					4'd0: cheat_code.flags[15:0] <= word.data;
					4'd2: cheat_code.flags[31:16] <= word.data;
					4'd4: cheat_code.address[15:0] <= word.data;
					4'd6: cheat_code.address[31:16] <= word.data;
					4'd8: cheat_code.compare[15:0] <= word.data;
					4'd10: cheat_code.compare[31:16] <= word.data;
					4'd12: cheat_code.replace[15:0] <= word.data;
					4'd14: begin
						// Last half completes the record
						cheat_code.replace[31:16] <= word.data;
						cheat_valid <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// Engine drops its codes on a new cartridge or a new cheat file
	always_ff @(posedge clk_sys) begin
		if (!reset)
			cheat_clear <= 1'b0;
		else
			cheat_clear <= cart_loading | first_word;
	end

endmodule

`default_nettype wire

// File: design/download_decode.sv
/* Download word decode stage */

`default_nettype none

module download_decode import cart_loader_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input logic download,
	input logic wr,
	input logic [7:0] index,
	input logic [ADDR_W-1:0] addr,
	input logic [DATA_W-1:0] data,
	output dl_word_t word,
	output logic word_valid,
	output logic cart_loading,
	output logic cheat_loading
);

	logic is_cheat;
	logic accept;

	// File type is decided here only
	assign is_cheat = (index == CHEAT_INDEX);
	assign accept = wr & download;

	// ==============================
	// Word register
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			word.is_cheat <= is_cheat;
			word.addr <= addr;
			// Image relative address, past the copier header
			word.code_addr <= addr - ADDR_W'(HEADER_SKIP);
			word.data <= data;
		end
	end

	// ==============================
	// Strobe and loading levels
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			word_valid <= 1'b0;
			cart_loading <= 1'b0;
			cheat_loading <= 1'b0;
		end else begin
			word_valid <= accept;
			cart_loading <= download & ~is_cheat;
			cheat_loading <= download & is_cheat;
		end
	end

endmodule

`default_nettype wire

// File: design/header_detect.sv
/* ROM header detection */

`default_nettype none

module header_detect import cart_loader_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input dl_word_t word,
	input logic word_valid,
	input logic cart_loading,
	input header_mode_e header_mode,
	output cart_info_t cart_info
);

	logic cart_wr;
	logic [3:0] rom_size;
	logic [3:0] ram_size;
	logic [3:0] rom_size_nxt;
	logic [3:0] ram_size_nxt;
	logic [7:0] rom_type_nxt;
	logic region_nxt;
	logic [ADDR_W-1:0] size_addr;
	logic [ADDR_W-1:0] ram_addr;
	logic fixed_mode;

	// Byte mask for a size code, 1 KiB times two to the code
	function automatic logic [23:0] size_mask(input logic [3:0] code);
		logic [23:0] base;
		base = 24'(MASK_BASE);
		return (base << code) - 24'd1;
	endfunction

	assign cart_wr = word_valid & cart_loading;

	// ==============================
	// Size offsets of the fixed modes
	// ==============================
	always_comb begin
		fixed_mode = 1'b1;
		size_addr = LOROM_SIZE_ADDR;
		ram_addr = LOROM_RAM_ADDR;
		case (header_mode)
			HDR_LOROM: begin
				size_addr = LOROM_SIZE_ADDR;
				ram_addr = LOROM_RAM_ADDR;
			end
			HDR_HIROM: begin
				size_addr = HIROM_SIZE_ADDR;
				ram_addr = HIROM_RAM_ADDR;
			end
			HDR_EXHIROM: begin
				size_addr = EXHIROM_SIZE_ADDR;
				ram_addr = EXHIROM_RAM_ADDR;
			end
			default: fixed_mode = 1'b0;
		endcase
	end

	// ==============================
	// Header rule
	// ==============================
	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		rom_type_nxt = cart_info.rom_type;
		region_nxt = cart_info.region;

		if (word.addr == '0) begin
			rom_size_nxt = DEFAULT_ROM_SIZE;
			ram_size_nxt = 4'h0;
			// Auto mode trusts a nonzero size byte in the first word
			if (header_mode == HDR_AUTO && word.data[7:0] != 8'h00) begin
				rom_size_nxt = word.data[3:0];
				ram_size_nxt = word.data[7:4];
			end
			case (header_mode)
				HDR_NONE, HDR_LOROM: rom_type_nxt = 8'd0;
				HDR_HIROM: rom_type_nxt = 8'd1;
				HDR_EXHIROM: rom_type_nxt = 8'd2;
				default: rom_type_nxt = word.data[15:8];
			endcase
		end

		if (word.addr == ADDR_W'(2))
			region_nxt = word.data[8];

		if (fixed_mode && word.addr == size_addr)
			rom_size_nxt = word.data[11:8];
		if (fixed_mode && word.addr == ram_addr)
			ram_size_nxt = word.data[3:0];
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size <= DEFAULT_ROM_SIZE;
			ram_size <= 4'h0;
			cart_info <= '0;
		end else if (cart_wr) begin
			rom_size <= rom_size_nxt;
			ram_size <= ram_size_nxt;
			cart_info.rom_type <= rom_type_nxt;
			cart_info.rom_mask <= size_mask(rom_size_nxt);
			// No RAM when the code is zero
			cart_info.ram_mask <= (ram_size_nxt != 4'h0) ? size_mask(ram_size_nxt) : 24'd0;
			cart_info.region <= region_nxt;
		end
	end

endmodule

`default_nettype wire

// File: sim.f
design/cart_loader_pkg.sv
design/download_decode.sv
design/header_detect.sv
design/cheat_assemble.sv
design/cart_loader_top.sv
verif/cart_loader_assert.sv
verif/cart_loader_tb.sv

// File: verif/cart_loader_assert.sv
/* Cartridge loader output checks */

`default_nettype none

module cart_loader_assert import cart_loader_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input logic download,
	input logic wr,
	input logic [7:0] index,
	input logic cheat_valid,
	input logic cheat_clear
);

	// Record strobe is a single cycle pulse
	no_long_valid: assert property (@(posedge clk_sys) disable iff (!reset)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid held for two cycles");

	// Pulse follows an accepted cheat write by two cycles
	valid_after_write: assert property (@(posedge clk_sys) disable iff (!reset)
		$rose(cheat_valid) |-> $past(wr & download & (index == CHEAT_INDEX), 2))
		else $error("cheat_valid without a cheat write two cycles before");

	reset_outputs_low: assert property (@(posedge clk_sys)
		!reset |=> (!cheat_valid && !cheat_clear))
		else $error("control outputs not low during reset");

endmodule

bind cart_loader_top cart_loader_assert cart_loader_assert_i (
	.clk_sys(clk_sys),
	.reset(reset),
	.download(download),
	.wr(wr),
	.index(index),
	.cheat_valid(cheat_valid),
	.cheat_clear(cheat_clear)
);

`default_nettype wire

// File: verif/cart_loader_tb.sv
/* Cartridge loader testbench */

`default_nettype none

module cart_loader_tb import cart_loader_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_WORDS = 256;
	// Worst case cycles of all test groups with random gaps
	localparam int TEST_CYCLES = RESET_CYCLES + 56 + 56 + 22 + 14 + 8 * 57 + 5;

	// One sampled input cycle
	typedef struct packed {
		logic accept;
		logic cheat;
		logic dl;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		header_mode_e mode;
	} in_sample_t;

	logic clk_sys;
	logic reset;
	logic download;
	logic wr;
	logic [7:0] index;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data;
	header_mode_e header_mode;
	cart_info_t cart_info;
	cheat_code_t cheat_code;
	logic cheat_valid;
	logic cheat_clear;

	// ==============================
	// Reference model state
	// ==============================
	logic [ADDR_W-1:0] cart_addr [MAX_WORDS];
	logic [DATA_W-1:0] cart_data [MAX_WORDS];
	header_mode_e cart_mode [MAX_WORDS];
	int cart_count;
	logic [7:0][DATA_W-1:0] halves;
	in_sample_t h1;
	in_sample_t h2;
	int count1;
	int count2;
	cheat_code_t rec1;
	cheat_code_t rec2;
	int pulse_count;
	int exp_pulse_count;

	cart_loader_top cart_loader_top_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.download(download),
		.wr(wr),
		.index(index),
		.addr(addr),
		.data(data),
		.header_mode(header_mode),
		.cart_info(cart_info),
		.cheat_code(cheat_code),
		.cheat_valid(cheat_valid),
		.cheat_clear(cheat_clear)
	);

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	function automatic logic [23:0] size_to_mask(input logic [3:0] code);
		logic [63:0] bytes;
		bytes = (64'(MASK_BASE) << code) - 64'd1;
		return bytes[23:0];
	endfunction

	// Replays every cartridge word since reset
	function automatic cart_info_t ref_header(input int count);
		cart_info_t info;
		logic [3:0] rom_code;
		logic [3:0] ram_code;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		header_mode_e m;
		int i;
		info = '0;
		rom_code = DEFAULT_ROM_SIZE;
		ram_code = 4'h0;
		for (i = 0; i < count; i++) begin
			a = cart_addr[i];
			d = cart_data[i];
			m = cart_mode[i];
			if (a == '0) begin
				rom_code = DEFAULT_ROM_SIZE;
				ram_code = 4'h0;
				if (m == HDR_AUTO && d[7:0] != 8'h00) begin
					rom_code = d[3:0];
					ram_code = d[7:4];
				end
				if (m == HDR_NONE || m == HDR_LOROM)
					info.rom_type = 8'd0;
				else if (m == HDR_HIROM)
					info.rom_type = 8'd1;
				else if (m == HDR_EXHIROM)
					info.rom_type = 8'd2;
				else
					info.rom_type = d[15:8];
			end
			if (a == ADDR_W'(2))
				info.region = d[8];
			if ((m == HDR_LOROM && a == LOROM_SIZE_ADDR) || (m == HDR_HIROM && a == HIROM_SIZE_ADDR)
					|| (m == HDR_EXHIROM && a == EXHIROM_SIZE_ADDR))
				rom_code = d[11:8];
			if ((m == HDR_LOROM && a == LOROM_RAM_ADDR) || (m == HDR_HIROM && a == HIROM_RAM_ADDR)
					|| (m == HDR_EXHIROM && a == EXHIROM_RAM_ADDR))
				ram_code = d[3:0];
			info.rom_mask = size_to_mask(rom_code);
			info.ram_mask = (ram_code == 4'h0) ? 24'd0 : size_to_mask(ram_code);
		end
		return info;
	endfunction

	// Halves in nibble order 0, 2, ... 14
	function automatic cheat_code_t ref_cheat(input logic [7:0][DATA_W-1:0] h);
		cheat_code_t rec;
		rec.flags = {h[1], h[0]};
		rec.address = {h[3], h[2]};
		rec.compare = {h[5], h[4]};
		rec.replace = {h[7], h[6]};
		return rec;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TB FAILED");
		$fatal(1);
	endtask

	// ==============================
	// Compare process
	// ==============================
	always @(negedge clk_sys) begin : compare
		in_sample_t cur;
		logic exp_clear;
		logic exp_valid;
		cart_info_t exp_info;
		cur.accept = wr & download;
		cur.cheat = (index == CHEAT_INDEX);
		cur.dl = download;
		cur.addr = addr;
		cur.data = data;
		cur.mode = header_mode;
		if (reset) begin
			exp_clear = (h2.dl & ~h2.cheat) | (h2.accept & h2.cheat & (h2.addr == '0));
			assert (cheat_clear === exp_clear) else
				report_failure($sformatf("[FAIL] cheat_clear expected %h got %h", exp_clear,
					cheat_clear));
			exp_valid = h2.accept & h2.cheat & ((h2.addr - ADDR_W'(HEADER_SKIP)) % 16 == 14);
			assert (cheat_valid === exp_valid) else
				report_failure($sformatf("[FAIL] cheat_valid expected %h got %h", exp_valid,
					cheat_valid));
			if (cheat_valid) begin
				pulse_count++;
				assert (cheat_code === rec2) else
					report_failure($sformatf("[FAIL] cheat_code expected %h got %h", rec2,
						cheat_code));
			end
			// Cheat words must leave the cartridge description alone
			if (h2.accept) begin
				exp_info = ref_header(count2);
				assert (cart_info === exp_info) else
					report_failure($sformatf("[FAIL] cart_info expected %h got %h", exp_info,
						cart_info));
			end
		end
		// Model update and two cycle pipeline
		rec2 = rec1;
		if (cur.accept && !cur.cheat) begin
			cart_addr[cart_count] = cur.addr;
			cart_data[cart_count] = cur.data;
			cart_mode[cart_count] = cur.mode;
			cart_count++;
		end
		if (cur.accept && cur.cheat && cur.addr[0] == 1'b0) begin
			halves[cur.addr[3:1]] = cur.data;
			if (cur.addr[3:0] == 4'd14) begin
				rec1 = ref_cheat(halves);
				exp_pulse_count++;
			end
		end
		count2 = count1;
		count1 = cart_count;
		h2 = h1;
		h1 = cur;
	end

	// ==============================
	// Stimulus
	// ==============================
	task automatic start_file(input logic [7:0] idx, input header_mode_e mode);
		@(posedge clk_sys);
		download <= 1'b1;
		wr <= 1'b0;
		index <= idx;
		header_mode <= mode;
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		@(posedge clk_sys);
		wr <= 1'b1;
		addr <= a;
		data <= d;
	endtask

	task automatic pause(input logic enable);
		int n;
		n = enable ? $urandom_range(2, 0) : 0;
		repeat (n) @(posedge clk_sys) wr <= 1'b0;
	endtask

	// Mode must stay stable until the last word has passed the pipeline
	task automatic end_file();
		@(posedge clk_sys);
		wr <= 1'b0;
		download <= 1'b0;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic cart_file(input header_mode_e mode, input logic gaps);
		logic [ADDR_W-1:0] offsets [6];
		logic [DATA_W-1:0] first;
		int k;
		offsets[0] = LOROM_SIZE_ADDR;
		offsets[1] = LOROM_RAM_ADDR;
		offsets[2] = HIROM_SIZE_ADDR;
		offsets[3] = HIROM_RAM_ADDR;
		offsets[4] = EXHIROM_SIZE_ADDR;
		offsets[5] = EXHIROM_RAM_ADDR;
		first = 16'($urandom);
		if (first[7:0] == 8'h00)
			first[0] = 1'b1;
		start_file(8'($urandom_range(254, 0)), mode);
		write_word('0, first);
		pause(gaps);
		write_word(ADDR_W'(2), 16'($urandom));
		for (k = 0; k < 6; k++) begin
			pause(gaps);
			write_word(offsets[k], 16'($urandom));
		end
		end_file();
	endtask

	task automatic cheat_file(input logic with_zero, input int records, input logic gaps);
		int r;
		int k;
		start_file(CHEAT_INDEX, HDR_AUTO);
		if (with_zero)
			write_word('0, 16'($urandom));
		for (r = 0; r < records; r++) begin
			for (k = 0; k < 8; k++) begin
				pause(gaps);
				write_word(ADDR_W'(HEADER_SKIP + 16 * r + 2 * k), 16'($urandom));
			end
		end
		end_file();
	endtask

	initial begin : stimulus
		int i;
		void'($urandom(32'h5f8c));
		reset = 1'b0;
		download = 1'b0;
		wr = 1'b0;
		index = 8'h00;
		addr = '0;
		data = '0;
		header_mode = HDR_AUTO;
		h1 = '0;
		h2 = '0;
		count1 = 0;
		count2 = 0;
		cart_count = 0;
		halves = '0;
		rec1 = '0;
		rec2 = '0;
		pulse_count = 0;
		exp_pulse_count = 0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b1;

		for (i = 0; i < 4; i++)
			cart_file(HDR_AUTO, 1'b0);
		cart_file(HDR_NONE, 1'b0);
		cart_file(HDR_LOROM, 1'b0);
		cart_file(HDR_HIROM, 1'b0);
		cart_file(HDR_EXHIROM, 1'b0);

		cheat_file(1'b0, 2, 1'b0);

		// Clear on address zero only
		cheat_file(1'b1, 0, 1'b0);
		start_file(CHEAT_INDEX, HDR_AUTO);
		write_word(ADDR_W'(25'h300), 16'($urandom));
		end_file();

		for (i = 0; i < 8; i++) begin
			if ($urandom_range(1, 0) == 1)
				cart_file(header_mode_e'($urandom_range(4, 0)), 1'b1);
			else
				cheat_file(1'($urandom_range(1, 0)), 2, 1'b1);
		end

		repeat (5) @(posedge clk_sys);
		if (pulse_count == exp_pulse_count && exp_pulse_count >= 2) begin
			$display("TB PASSED");
			$finish;
		end else begin
			report_failure("Number of cheat records does not match the written cheat words");
		end
	end

	initial begin : watchdog
		#(2 * TEST_CYCLES * CLK_PERIOD);
		report_failure("Timeout, the test sequence did not finish in time");
	end

endmodule

`default_nettype wire
